// File: img_gradient.f
source/grad_pkg.sv
source/img_scan.sv
source/row_delay.sv
source/grad_calc.sv
source/img_gradient.sv
tb/grad_monitor.sv
tb/tb_img_gradient.sv

// File: source/grad_calc.sv
`timescale 1ns/100ps

module grad_calc (
    input  logic              clk,
    input  logic              reset,
    input  logic              tap_valid,
    input  grad_pkg::coord_t  tap_col,
    input  grad_pkg::coord_t  tap_row,
    input  grad_pkg::pixel_t  tap_here,
    input  grad_pkg::pixel_t  tap_right,
    input  grad_pkg::pixel_t  tap_below,
    output logic              grad_wr,
    output grad_pkg::addr_t   grad_addr,
    output grad_pkg::grad_t   grad_do
);

    // zero-extended operands
    grad_pkg::diff_t here_ext;
    grad_pkg::diff_t right_ext;
    grad_pkg::diff_t below_ext;

    // raw and edge-corrected differences
    grad_pkg::diff_t dx_raw;
    grad_pkg::diff_t dy_raw;
    grad_pkg::diff_t dx;
    grad_pkg::diff_t dy;

    logic last_col;
    logic last_row;

    // ------------------------------
    // differences
    // ------------------------------
    assign last_col = (tap_col == grad_pkg::coord_t'(grad_pkg::img_w - 1));
    assign last_row = (tap_row == grad_pkg::coord_t'(grad_pkg::img_h - 1));

    always_comb begin
        here_ext  = grad_pkg::diff_t'({2'b00, tap_here});
        right_ext = grad_pkg::diff_t'({2'b00, tap_right});
        below_ext = grad_pkg::diff_t'({2'b00, tap_below});

        // range is -255..255, fits in 10 bits signed
        dx_raw = right_ext - here_ext;
        dy_raw = below_ext - here_ext;

        // right neighbour at the last column belongs to the next row
        if (last_col) begin
            dx = '0;
        end else begin
            dx = dx_raw;
        end

        // below the last row is flush data
        if (last_row) begin
            dy = '0;
        end else begin
            dy = dy_raw;
        end
    end

    // ------------------------------
    // write register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr <= 1'b0;
        end else begin
            grad_wr <= tap_valid;
        end
    end

    always_ff @(posedge clk) begin
        grad_addr <= {tap_row, tap_col};
        grad_do   <= {dx, dy};
    end

endmodule

// File: source/grad_pkg.sv
package grad_pkg;

    // ------------------------------
    // image geometry
    // ------------------------------
    localparam int img_w      = 256;
    localparam int img_h      = 256;
    localparam int img_pixels = img_w * img_h;

    // field widths
    localparam int pixel_w = 8;
    localparam int coord_w = 8;
    localparam int addr_w  = 16;
    localparam int diff_w  = 10;

    // ------------------------------
    // data types
    // ------------------------------
    typedef logic [pixel_w-1:0] pixel_t;
    typedef logic [addr_w-1:0] addr_t;
    typedef logic [coord_w-1:0] coord_t;
    typedef logic signed [diff_w-1:0] diff_t;

    // horizontal difference in the upper half, vertical in the lower
    typedef logic [2*diff_w-1:0] grad_t;

    // scanner states
    typedef enum logic [1:0] {
        idle,
        read_rows,
        flush_row,
        finish
    } scan_state_t;

endpackage

// File: source/img_gradient.sv
`timescale 1ns/100ps

module img_gradient (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  grad_pkg::pixel_t  img_di,
    output logic              img_rd,
    output grad_pkg::addr_t   img_addr,
    output logic              grad_wr,
    output grad_pkg::addr_t   grad_addr,
    output grad_pkg::grad_t   grad_do,
    output logic              done
);

    // tagged incoming pixel
    logic              pix_valid;
    logic              pix_flush;
    grad_pkg::coord_t  pix_col;
    grad_pkg::coord_t  pix_row;

    // delay line taps
    logic              tap_valid;
    grad_pkg::coord_t  tap_col;
    grad_pkg::coord_t  tap_row;
    grad_pkg::pixel_t  tap_here;
    grad_pkg::pixel_t  tap_right;
    grad_pkg::pixel_t  tap_below;

    // ------------------------------
    // scanner
    // ------------------------------
    img_scan u_scan (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .pix_valid (pix_valid),
        .pix_flush (pix_flush),
        .pix_col   (pix_col),
        .pix_row   (pix_row),
        .done      (done)
    );

    // one row of history
    row_delay u_delay (
        .clk       (clk),
        .reset     (reset),
        .pix_valid (pix_valid),
        .pix_flush (pix_flush),
        .pix_col   (pix_col),
        .pix_row   (pix_row),
        .img_di    (img_di),
        .tap_valid (tap_valid),
        .tap_col   (tap_col),
        .tap_row   (tap_row),
        .tap_here  (tap_here),
        .tap_right (tap_right),
        .tap_below (tap_below)
    );

    // differences and memory write
    grad_calc u_calc (
        .clk       (clk),
        .reset     (reset),
        .tap_valid (tap_valid),
        .tap_col   (tap_col),
        .tap_row   (tap_row),
        .tap_here  (tap_here),
        .tap_right (tap_right),
        .tap_below (tap_below),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do)
    );

endmodule

// File: source/img_scan.sv
`timescale 1ns/100ps

module img_scan (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    output logic              img_rd,
    output grad_pkg::addr_t   img_addr,
    output logic              pix_valid,
    output logic              pix_flush,
    output grad_pkg::coord_t  pix_col,
    output grad_pkg::coord_t  pix_row,
    output logic              done
);

    grad_pkg::scan_state_t state;
    grad_pkg::coord_t      col_cnt;
    grad_pkg::coord_t      row_cnt;

    // a pixel slot is issued this cycle, read or flush
    logic issue;
    logic flush_issue;
    logic last_col;

    // mirrors the write register in grad_calc
    logic wr_pend;

    // ------------------------------
    // address and strobes
    // ------------------------------
    assign img_addr    = {row_cnt, col_cnt};
    assign img_rd      = (state == grad_pkg::read_rows);
    assign flush_issue = (state == grad_pkg::flush_row);
    assign issue       = img_rd || flush_issue;
    assign last_col    = (col_cnt == grad_pkg::coord_t'(grad_pkg::img_w - 1));

    // ------------------------------
    // scan state machine
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= grad_pkg::idle;
            col_cnt <= '0;
            row_cnt <= '0;
            done    <= 1'b0;
        end else begin
            case (state)
                grad_pkg::idle: begin
                    // start only honoured here, so a busy engine ignores it
                    if (start) begin
                        state   <= grad_pkg::read_rows;
                        col_cnt <= '0;
                        row_cnt <= '0;
                        done    <= 1'b0;
                    end
                end

                grad_pkg::read_rows: begin
                    col_cnt <= col_cnt + 1'b1;
                    if (last_col) begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                    // row counter wraps to 0, which tags the flush row
                    if (img_addr == grad_pkg::addr_t'(grad_pkg::img_pixels - 1)) begin
                        state <= grad_pkg::flush_row;
                    end
                end

                grad_pkg::flush_row: begin
                    col_cnt <= col_cnt + 1'b1;
                    if (last_col) begin
                        state <= grad_pkg::finish;
                    end
                end

                grad_pkg::finish: begin
                    // last flush pixel now sits in the write register
                    if (!pix_valid && wr_pend) begin
                        done  <= 1'b1;
                        state <= grad_pkg::idle;
                    end
                end

                default: begin
                    state <= grad_pkg::idle;
                end
            endcase
        end
    end

    // ------------------------------
    // tag for returning data
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pix_valid <= 1'b0;
            pix_flush <= 1'b0;
            wr_pend   <= 1'b0;
        end else begin
            pix_valid <= issue;
            pix_flush <= flush_issue;
            wr_pend   <= pix_valid;
        end
    end

    // coordinates of the pixel arriving next cycle
    always_ff @(posedge clk) begin
        pix_col <= col_cnt;
        pix_row <= row_cnt;
    end

endmodule

// File: source/row_delay.sv
`timescale 1ns/100ps

module row_delay (
    input  logic              clk,
    input  logic              reset,
    input  logic              pix_valid,
    input  logic              pix_flush,
    input  grad_pkg::coord_t  pix_col,
    input  grad_pkg::coord_t  pix_row,
    input  grad_pkg::pixel_t  img_di,
    output logic              tap_valid,
    output grad_pkg::coord_t  tap_col,
    output grad_pkg::coord_t  tap_row,
    output grad_pkg::pixel_t  tap_here,
    output grad_pkg::pixel_t  tap_right,
    output grad_pkg::pixel_t  tap_below
);

    // pixel entering the chain, zero during the flush row
    grad_pkg::pixel_t pix_in;

    // line_q[k] holds the pixel k positions before the incoming one
    grad_pkg::pixel_t line_q [1:grad_pkg::img_w];

    assign pix_in = pix_flush ? '0 : img_di;

    // ------------------------------
    // line buffer
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 1; k <= grad_pkg::img_w; k++) begin
                line_q[k] <= '0;
            end
        end else if (pix_valid) begin
            line_q[1] <= pix_in;
            for (int k = 2; k <= grad_pkg::img_w; k++) begin
                line_q[k] <= line_q[k-1];
            end
        end
    end

    // ------------------------------
    // taps
    // ------------------------------
    // one row back is the pixel above, one less is its right neighbour
    assign tap_here  = line_q[grad_pkg::img_w];
    assign tap_right = line_q[grad_pkg::img_w - 1];
    assign tap_below = pix_in;

    // row 0 has nothing above it, so no output yet
    assign tap_valid = pix_valid && (pix_flush || (pix_row != '0));

    // flush row carries row 0, so minus one lands on the last row
    assign tap_col = pix_col;
    assign tap_row = pix_row - 1'b1;

endmodule

// File: tb/grad_input.txt
# name kind base col_step row_step exp_h exp_v
# ramp pixel is base + col_step*col + row_step*row, exp values are interior gradients
col_ramp ramp 0 1 0 1 0
row_ramp ramp 0 0 1 0 1
col_fall ramp 255 -1 0 -1 0
row_fall ramp 255 0 -1 0 -1
flat ramp 77 0 0 0 0
noise_a random 0 0 0 0 0
noise_b random 0 0 0 0 0

// File: tb/grad_monitor.sv
`timescale 1ns/100ps

module grad_monitor (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic              img_rd,
    input  grad_pkg::addr_t   img_addr,
    input  grad_pkg::pixel_t  img_di,
    input  logic              grad_wr,
    input  grad_pkg::addr_t   grad_addr,
    input  grad_pkg::grad_t   grad_do,
    input  logic              done,
    input  logic [127:0]      test_name,
    input  logic              test_ramp,
    input  int                exp_h,
    input  int                exp_v,
    output int                tests_passed,
    output int                tests_failed,
    output int                err_count
);

    localparam int n_pix     = grad_pkg::img_w * grad_pkg::img_h;
    localparam int max_print = 10;

    // image as seen on the read port
    grad_pkg::pixel_t image [0:n_pix-1];

    // samples from the previous edge
    logic            rd_q;
    logic            wr_q;
    logic            done_q;
    logic            reset_q;
    grad_pkg::addr_t rd_addr_q;

    logic running;
    int   rd_count;
    int   wr_count;
    int   next_addr;

    function automatic string name_text(input logic [127:0] bits);
        string s;
        logic [7:0] ch;
        s = "";
        for (int i = 15; i >= 0; i--) begin
            ch = bits[i*8 +: 8];
            if (ch != 8'h00) begin
                s = $sformatf("%s%c", s, ch);
            end
        end
        return s;
    endfunction

    task automatic log_error(input string msg);
        err_count++;
        if (err_count <= max_print) begin
            $display("%s", msg);
        end else if (err_count == max_print + 1) begin
            $display("%s: further errors not shown", name_text(test_name));
        end
    endtask

    // ------------------------------
    // one gradient write
    // ------------------------------
    task automatic check_write();
        int a;
        int c;
        int r;
        int here;
        int dx;
        int dy;
        int got_h;
        int got_v;
        int want_h;
        int want_v;
        grad_pkg::grad_t want;
        a = int'(grad_addr);
        c = a % grad_pkg::img_w;
        r = a / grad_pkg::img_w;
        if (!running) begin
            log_error($sformatf("gradient write to address %0d outside a run", a));
        end else if (a > next_addr) begin
            log_error($sformatf("%s: addresses %0d to %0d were never written",
                                name_text(test_name), next_addr, a - 1));
        end else if (a < next_addr) begin
            log_error($sformatf("%s: address %0d written twice or out of order",
                                name_text(test_name), a));
        end
        wr_count++;
        next_addr = a + 1;
        here = image[a];
        dx = 0;
        dy = 0;
        if (c != grad_pkg::img_w - 1) begin
            dx = int'(image[a + 1]) - here;
        end
        if (r != grad_pkg::img_h - 1) begin
            dy = int'(image[a + grad_pkg::img_w]) - here;
        end
        want = {dx[9:0], dy[9:0]};
        if (grad_do !== want) begin
            log_error($sformatf("Mismatch %s addr %0d: expected %05h, actual %05h",
                                name_text(test_name), a, want, grad_do));
        end
        if (test_ramp) begin
            // ramp interior follows the steps and the edges stay zero
            got_h  = int'($signed(grad_do[19:10]));
            got_v  = int'($signed(grad_do[9:0]));
            want_h = (c == grad_pkg::img_w - 1) ? 0 : exp_h;
            want_v = (r == grad_pkg::img_h - 1) ? 0 : exp_v;
            if (got_h != want_h || got_v != want_v) begin
                log_error($sformatf("Mismatch %s addr %0d ramp: expected %0d/%0d, actual %0d/%0d",
                                    name_text(test_name), a, want_h, want_v, got_h, got_v));
            end
        end
    endtask

    task automatic end_test();
        if (rd_count != n_pix) begin
            log_error($sformatf("%s: %0d image reads instead of %0d",
                                name_text(test_name), rd_count, n_pix));
        end
        if (wr_count != n_pix) begin
            log_error($sformatf("%s: done raised after %0d writes instead of %0d",
                                name_text(test_name), wr_count, n_pix));
        end
        if (!wr_q) begin
            log_error($sformatf("%s: done did not rise in the cycle after the final write",
                                name_text(test_name)));
        end
        if (err_count == 0) begin
            tests_passed++;
            $display("test %s passed, %0d writes checked", name_text(test_name), wr_count);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name_text(test_name), err_count);
        end
        err_count = 0;
        running   = 0;
    endtask

    initial begin
        tests_passed = 0;
        tests_failed = 0;
        err_count    = 0;
        running      = 0;
        rd_q         = 0;
        wr_q         = 0;
        done_q       = 0;
        reset_q      = 0;
    end

    // ------------------------------
    // sampling on each edge
    // ------------------------------
    always @(posedge clk) begin
        if (reset) begin
            reset_q = 1;
            running = 0;
            rd_q    = 0;
            wr_q    = 0;
            done_q  = 0;
        end else begin
            if (reset_q && (img_rd !== 1'b0 || grad_wr !== 1'b0 || done !== 1'b0)) begin
                log_error("img_rd, grad_wr or done was not low after reset");
            end
            reset_q = 0;
            // data for last cycle's read is on img_di now
            if (rd_q) begin
                image[rd_addr_q] = img_di;
            end
            if (start && !running) begin
                running   = 1;
                rd_count  = 0;
                wr_count  = 0;
                next_addr = 0;
            end
            if (img_rd) begin
                if (!running || img_addr !== grad_pkg::addr_t'(rd_count)) begin
                    log_error($sformatf("%s: read of address %0d, expected %0d",
                                        name_text(test_name), img_addr, rd_count));
                end
                rd_count++;
            end
            if (grad_wr) begin
                check_write();
            end
            if (done && !done_q) begin
                if (running) begin
                    end_test();
                end else begin
                    log_error("done rose without a run in progress");
                end
            end
            rd_q      = img_rd;
            rd_addr_q = img_addr;
            wr_q      = grad_wr;
            done_q    = done;
        end
    end

endmodule

// File: tb/tb_img_gradient.sv
`timescale 1ns/100ps

module tb_img_gradient;

    localparam int  max_tests       = 32;
    localparam int  n_pix           = grad_pkg::img_w * grad_pkg::img_h;
    localparam int  cycles_per_test = 66000;
    localparam real clk_period      = 8.0;

    logic              clk;
    logic              reset;
    logic              start;
    grad_pkg::pixel_t  img_di;
    logic              img_rd;
    grad_pkg::addr_t   img_addr;
    logic              grad_wr;
    grad_pkg::addr_t   grad_addr;
    grad_pkg::grad_t   grad_do;
    logic              done;

    // image memory model
    grad_pkg::pixel_t img_mem [0:n_pix-1];

    // test table from the input file
    logic [127:0] tab_name [0:max_tests-1];
    logic         tab_ramp [0:max_tests-1];
    int           tab_base [0:max_tests-1];
    int           tab_cs   [0:max_tests-1];
    int           tab_rs   [0:max_tests-1];
    int           tab_eh   [0:max_tests-1];
    int           tab_ev   [0:max_tests-1];
    int           n_tests;
    logic         loaded;

    logic [31:0]  lfsr;
    logic [127:0] cur_name;
    logic         cur_ramp;
    int           cur_exp_h;
    int           cur_exp_v;
    int           tests_passed;
    int           tests_failed;

    // errors seen outside any finished test
    int           monitor_errors;

    img_gradient DUT (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .img_di    (img_di),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    grad_monitor u_monitor (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .img_rd       (img_rd),
        .img_addr     (img_addr),
        .img_di       (img_di),
        .grad_wr      (grad_wr),
        .grad_addr    (grad_addr),
        .grad_do      (grad_do),
        .done         (done),
        .test_name    (cur_name),
        .test_ramp    (cur_ramp),
        .exp_h        (cur_exp_h),
        .exp_v        (cur_exp_v),
        .tests_passed (tests_passed),
        .tests_failed (tests_failed),
        .err_count    (monitor_errors)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2.0) clk = ~clk;
    end

    // read data one edge after the strobe
    always @(posedge clk) begin
        if (img_rd) begin
            img_di <= img_mem[img_addr];
        end
    end

    // galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // ------------------------------
    // test file and image fill
    // ------------------------------
    task automatic load_tests();
        int               fd;
        int               n;
        logic [8*128-1:0] line;
        logic [127:0]     name;
        logic [127:0]     kind;
        int               base;
        int               cs;
        int               rs;
        int               eh;
        int               ev;
        fd = $fopen("tb/grad_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/grad_input.txt");
        end else begin
            while (!$feof(fd) && n_tests < max_tests) begin
                line = '0;
                if ($fgets(line, fd) != 0) begin
                    // comment and blank lines do not yield seven fields
                    n = $sscanf(line, "%s %s %d %d %d %d %d", name, kind, base, cs, rs, eh, ev);
                    if (n == 7) begin
                        tab_name[n_tests] = name;
                        tab_ramp[n_tests] = (kind == "ramp");
                        tab_base[n_tests] = base;
                        tab_cs[n_tests]   = cs;
                        tab_rs[n_tests]   = rs;
                        tab_eh[n_tests]   = eh;
                        tab_ev[n_tests]   = ev;
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic fill_image(input int idx);
        int         v;
        logic [7:0] pix;
        for (int a = 0; a < n_pix; a++) begin
            if (tab_ramp[idx]) begin
                v = tab_base[idx] + tab_cs[idx] * (a % grad_pkg::img_w)
                    + tab_rs[idx] * (a / grad_pkg::img_w);
                img_mem[a] = grad_pkg::pixel_t'(v);
            end else begin
                for (int b = 0; b < 8; b++) begin
                    pix[b] = lfsr[0];
                    lfsr   = lfsr_next(lfsr);
                end
                img_mem[a] = pix;
            end
        end
    endtask

    task automatic run_test(input int idx);
        fill_image(idx);
        cur_name  = tab_name[idx];
        cur_ramp  = tab_ramp[idx];
        cur_exp_h = tab_eh[idx];
        cur_exp_v = tab_ev[idx];
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        do begin
            @(posedge clk);
        end while (done !== 1'b1);
        // keep the test name one more edge past the monitor's done check
        @(posedge clk);
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        reset     = 1'b1;
        start     = 1'b0;
        img_di    = '0;
        cur_name  = '0;
        cur_ramp  = 1'b0;
        cur_exp_h = 0;
        cur_exp_v = 0;
        lfsr      = 32'hd263_690e;
        n_tests   = 0;
        loaded    = 1'b0;
        load_tests();
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        @(posedge clk);
        $display("tests %0d, passed %0d, failed %0d", n_tests, tests_passed, tests_failed);
        if (n_tests > 0 && tests_failed == 0 && tests_passed == n_tests
            && monitor_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog
    initial begin
        int limit_tests;
        wait (loaded === 1'b1);
        limit_tests = (n_tests > 0) ? n_tests : 1;
        #(limit_tests * cycles_per_test * clk_period);
        $display("run timed out before all tests finished");
        $display("** FAIL **");
        $finish;
    end

endmodule
